// File: logic/dcache_bus_pkg.sv
// Data cache bus types

package dcache_bus_pkg;

  localparam int ADDR_W = 16; // Byte address
  localparam int DATA_W = 32; // One word per access and per beat

  // ----------------------------------------
  // CPU port
  // ----------------------------------------
  typedef struct packed {
    logic              valid;
    logic              we;
    logic [ADDR_W-1:0] addr;  // Word aligned
    logic [DATA_W-1:0] wdata;
  } cpu_req_t;

  typedef struct packed {
    logic              ack;   // Single cycle pulse
    logic [DATA_W-1:0] rdata;
  } cpu_rsp_t;

  // ----------------------------------------
  // Memory port, one word per beat
  // ----------------------------------------
  typedef struct packed {
    logic              valid;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic              ready;
    logic [DATA_W-1:0] rdata; // Valid with ready on reads
  } mem_rsp_t;

endpackage

// File: logic/dcache_cfg_pkg.sv
// Data cache configuration types

package dcache_cfg_pkg;

  // Default geometry, 16 sets of 4 words
  localparam int DEF_SETS       = 16;
  localparam int DEF_LINE_WORDS = 4;

  // One tag RAM entry per set
  // Tag holds the address shifted down past index and offset,
  // the upper bits stay zero
  typedef struct packed {
    logic                              valid;
    logic                              dirty;
    logic [dcache_bus_pkg::ADDR_W-1:0] tag;
  } tag_entry_t;

  // Controller states
  typedef enum logic [2:0] {
    IDLE,     // Wait for a CPU request
    LOOKUP,   // RAM outputs ready, tag compare
    EVICT_RD, // Read one victim word
    EVICT_WR, // Write it to memory
    FILL,     // Refill beats
    DONE      // Tag updated, back to IDLE for the re-read
  } ctrl_state_t;

endpackage

// File: logic/dcache_ram.sv
// Single port RAM with registered read

`timescale 1ns/1ps

module dcache_ram #(
  parameter type payload_t = logic [dcache_bus_pkg::DATA_W-1:0],
  parameter int  DEPTH     = 16
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [$clog2(DEPTH)-1:0] addr_i,
  input  logic                     we_i,
  input  payload_t                 wdata_i,
  output payload_t                 rdata_o
);

  payload_t         mem_q [DEPTH];
  logic [DEPTH-1:0] written_q; // Entry holds real data

  // Storage and read port, read returns the old contents on a write
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
    if (written_q[addr_i]) begin
      rdata_o <= mem_q[addr_i];
    end else begin
      rdata_o <= '0; // Never written, reads as zero
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      written_q <= '0;
    end else if (we_i) begin
      written_q[addr_i] <= 1'b1;
    end
  end

  // A write with an unknown address would corrupt an unknown entry
  a_we_addr_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    we_i |-> !$isunknown(addr_i));

endmodule

// File: logic/dcache_burst_cnt.sv
// Line word counter for bursts

`timescale 1ns/1ps

module dcache_burst_cnt #(
  parameter int LINE_WORDS = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  logic                          step_i,
  output logic [$clog2(LINE_WORDS)-1:0] offs_o,
  output logic                          last_o
);

  localparam int OFF_W = $clog2(LINE_WORDS);

  logic [OFF_W-1:0] offs_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offs_q <= '0;
    end else if (clear_i) begin
      offs_q <= '0; // Back to the line base
    end else if (step_i) begin
      offs_q <= offs_q + 1'b1;
    end
  end

  assign offs_o = offs_q;
  assign last_o = (offs_q == OFF_W'(LINE_WORDS - 1)); // Final word of the line

  // The controller must close a burst with clear, never step past the end
  a_no_step_at_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(step_i && last_o && !clear_i));

endmodule

// File: logic/dcache_ctrl.sv
// Data cache controller

`timescale 1ns/1ps

module dcache_ctrl #(
  parameter int SETS       = 16,
  parameter int LINE_WORDS = 4
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  dcache_bus_pkg::cpu_req_t                      cpu_req_i,
  output dcache_bus_pkg::cpu_rsp_t                      cpu_rsp_o,
  output dcache_bus_pkg::mem_req_t                      mem_req_o,
  input  dcache_bus_pkg::mem_rsp_t                      mem_rsp_i,
  output logic [$clog2(SETS)-1:0]                       tag_addr_o,
  output logic                                          tag_we_o,
  output dcache_cfg_pkg::tag_entry_t                    tag_wdata_o,
  input  dcache_cfg_pkg::tag_entry_t                    tag_rdata_i,
  output logic [$clog2(SETS)+$clog2(LINE_WORDS)-1:0]    data_addr_o,
  output logic                                          data_we_o,
  output logic [dcache_bus_pkg::DATA_W-1:0]             data_wdata_o,
  input  logic [dcache_bus_pkg::DATA_W-1:0]             data_rdata_i,
  output logic                                          cnt_clear_o,
  output logic                                          cnt_step_o,
  input  logic [$clog2(LINE_WORDS)-1:0]                 cnt_offs_i,
  input  logic                                          cnt_last_i
);

  localparam int AW      = dcache_bus_pkg::ADDR_W;
  localparam int IDX_W   = $clog2(SETS);
  localparam int OFF_W   = $clog2(LINE_WORDS);
  localparam int SET_LSB = OFF_W + 2;       // Word offset plus byte bits
  localparam int TAG_LSB = SET_LSB + IDX_W;

  dcache_cfg_pkg::ctrl_state_t state_q, state_d;

  logic [IDX_W-1:0] req_idx;
  logic [OFF_W-1:0] req_off;
  logic [AW-1:0]    req_tag;
  logic [AW-1:0]    set_base, beat_offs;
  logic [AW-1:0]    fill_addr, evict_addr;
  logic             in_burst;
  logic             hit;

  // ----------------------------------------
  // Address split and tag compare
  // ----------------------------------------
  assign req_idx = cpu_req_i.addr[SET_LSB +: IDX_W];
  assign req_off = cpu_req_i.addr[2 +: OFF_W];
  assign req_tag = cpu_req_i.addr >> TAG_LSB;

  assign set_base   = AW'(req_idx) << SET_LSB;
  assign beat_offs  = AW'(cnt_offs_i) << 2;
  assign fill_addr  = (req_tag << TAG_LSB) | set_base | beat_offs;
  assign evict_addr = (tag_rdata_i.tag << TAG_LSB) | set_base | beat_offs; // Victim line

  assign hit = tag_rdata_i.valid && (tag_rdata_i.tag == req_tag);

  // Burst states walk the line with the counter
  assign in_burst = (state_q == dcache_cfg_pkg::EVICT_RD) ||
                    (state_q == dcache_cfg_pkg::EVICT_WR) ||
                    (state_q == dcache_cfg_pkg::FILL);

  assign tag_addr_o  = req_idx; // Held, so the victim tag stays on tag_rdata_i
  assign data_addr_o = {req_idx, in_burst ? cnt_offs_i : req_off};

  // ----------------------------------------
  // FSM
  // ----------------------------------------
  always_comb begin
    state_d           = state_q;
    cpu_rsp_o.ack     = 1'b0;
    cpu_rsp_o.rdata   = data_rdata_i;
    mem_req_o.valid   = 1'b0;
    mem_req_o.we      = 1'b0;
    mem_req_o.addr    = fill_addr;
    mem_req_o.wdata   = '0;
    tag_we_o          = 1'b0;
    tag_wdata_o.valid = 1'b1;
    tag_wdata_o.dirty = (state_q == dcache_cfg_pkg::LOOKUP); // Clean after refill
    tag_wdata_o.tag   = req_tag;
    data_we_o         = 1'b0;
    data_wdata_o      = (state_q == dcache_cfg_pkg::FILL) ? mem_rsp_i.rdata : cpu_req_i.wdata;
    cnt_clear_o       = 1'b0;
    cnt_step_o        = 1'b0;

    case (state_q)
      dcache_cfg_pkg::IDLE: begin
        if (cpu_req_i.valid) state_d = dcache_cfg_pkg::LOOKUP; // RAMs read this edge
      end
      dcache_cfg_pkg::LOOKUP: begin
        if (hit) begin
          cpu_rsp_o.ack = 1'b1;
          data_we_o     = cpu_req_i.we;
          tag_we_o      = cpu_req_i.we; // Mark line dirty
          state_d       = dcache_cfg_pkg::IDLE;
        end else if (tag_rdata_i.valid && tag_rdata_i.dirty) begin
          state_d = dcache_cfg_pkg::EVICT_RD;
        end else begin
          state_d = dcache_cfg_pkg::FILL;
        end
      end
      dcache_cfg_pkg::EVICT_RD: begin
        state_d = dcache_cfg_pkg::EVICT_WR;
      end
      dcache_cfg_pkg::EVICT_WR: begin
        mem_req_o.valid = 1'b1;
        mem_req_o.we    = 1'b1;
        mem_req_o.addr  = evict_addr;
        mem_req_o.wdata = data_rdata_i; // Same address re-read while stalled
        if (mem_rsp_i.ready) begin
          cnt_clear_o = cnt_last_i;
          cnt_step_o  = !cnt_last_i;
          state_d     = cnt_last_i ? dcache_cfg_pkg::FILL : dcache_cfg_pkg::EVICT_RD;
        end
      end
      dcache_cfg_pkg::FILL: begin
        mem_req_o.valid = 1'b1;
        if (mem_rsp_i.ready) begin
          data_we_o   = 1'b1;
          cnt_clear_o = cnt_last_i;
          cnt_step_o  = !cnt_last_i;
          if (cnt_last_i) begin
            tag_we_o = 1'b1; // New line valid and clean
            state_d  = dcache_cfg_pkg::DONE;
          end
        end
      end
      dcache_cfg_pkg::DONE: begin
        state_d = dcache_cfg_pkg::IDLE; // Request is looked up again
      end
      default: state_d = dcache_cfg_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= dcache_cfg_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Bus rule, request held until accepted
  a_mem_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o.valid && !mem_rsp_i.ready |=> $stable(mem_req_o));

  // Every request gets exactly one ack
  a_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cpu_rsp_o.ack |=> !cpu_rsp_o.ack);

endmodule

// File: logic/dcache_top.sv
// Direct mapped data cache

`timescale 1ns/1ps

module dcache_top #(
  parameter int SETS       = dcache_cfg_pkg::DEF_SETS,
  parameter int LINE_WORDS = dcache_cfg_pkg::DEF_LINE_WORDS
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  dcache_bus_pkg::cpu_req_t cpu_req_i,
  output dcache_bus_pkg::cpu_rsp_t cpu_rsp_o,
  output dcache_bus_pkg::mem_req_t mem_req_o,
  input  dcache_bus_pkg::mem_rsp_t mem_rsp_i
);

  localparam int IDX_W = $clog2(SETS);
  localparam int OFF_W = $clog2(LINE_WORDS);
  localparam int DW    = dcache_bus_pkg::DATA_W;

  // Tag RAM, one entry per set
  logic [IDX_W-1:0]           tag_addr;
  logic                       tag_we;
  dcache_cfg_pkg::tag_entry_t tag_wdata, tag_rdata;

  // Data RAM, one word per entry
  logic [IDX_W+OFF_W-1:0] data_addr;
  logic                   data_we;
  logic [DW-1:0]          data_wdata, data_rdata;

  logic             cnt_clear, cnt_step, cnt_last;
  logic [OFF_W-1:0] cnt_offs;

  dcache_ctrl #(
    .SETS         (SETS),
    .LINE_WORDS   (LINE_WORDS)
  ) ctrl_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cpu_req_i    (cpu_req_i),
    .cpu_rsp_o    (cpu_rsp_o),
    .mem_req_o    (mem_req_o),
    .mem_rsp_i    (mem_rsp_i),
    .tag_addr_o   (tag_addr),
    .tag_we_o     (tag_we),
    .tag_wdata_o  (tag_wdata),
    .tag_rdata_i  (tag_rdata),
    .data_addr_o  (data_addr),
    .data_we_o    (data_we),
    .data_wdata_o (data_wdata),
    .data_rdata_i (data_rdata),
    .cnt_clear_o  (cnt_clear),
    .cnt_step_o   (cnt_step),
    .cnt_offs_i   (cnt_offs),
    .cnt_last_i   (cnt_last)
  );

  dcache_burst_cnt #(
    .LINE_WORDS (LINE_WORDS)
  ) burst_cnt_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (cnt_clear),
    .step_i     (cnt_step),
    .offs_o     (cnt_offs),
    .last_o     (cnt_last)
  );

  dcache_ram #(
    .payload_t (dcache_cfg_pkg::tag_entry_t),
    .DEPTH     (SETS)
  ) tag_ram_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .addr_i    (tag_addr),
    .we_i      (tag_we),
    .wdata_i   (tag_wdata),
    .rdata_o   (tag_rdata)
  );

  dcache_ram #(
    .payload_t (logic [DW-1:0]),
    .DEPTH     (SETS * LINE_WORDS)
  ) data_ram_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .addr_i    (data_addr),
    .we_i      (data_we),
    .wdata_i   (data_wdata),
    .rdata_o   (data_rdata)
  );

endmodule

// File: verif/dcache_mem_model.sv
// Behavioral burst memory

`timescale 1ns/1ps

module dcache_mem_model #(
  parameter int LINE_WORDS = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  dcache_bus_pkg::mem_req_t mem_req_i,
  output dcache_bus_pkg::mem_rsp_t mem_rsp_o,
  output logic                     order_err_o, // Burst not aligned, ascending or complete
  output logic                     hold_err_o   // Request changed while stalled
);

  localparam int LINE_LSB = $clog2(LINE_WORDS) + 2;
  localparam int WORDS    = 2 ** (dcache_bus_pkg::ADDR_W - 2);

  logic [dcache_bus_pkg::DATA_W-1:0] mem [WORDS];
  logic                              ready_q;
  integer                            seed;
  logic [31:0]                       rnd;
  int                                beat_cnt;
  logic [dcache_bus_pkg::ADDR_W-1:0] next_addr;
  logic                              burst_we;
  logic                              pend_q;
  dcache_bus_pkg::mem_req_t          last_req_q;

  initial begin
    seed    = 32'hd1876156;
    ready_q = 1'b0;
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = (32'(i) << 2) ^ 32'h5a5a0000; // Address XOR pattern
    end
  end

  assign mem_rsp_o = {ready_q, mem[mem_req_i.addr[dcache_bus_pkg::ADDR_W-1:2]]};

  // Ready changes shortly after the edge, like every other input
  always @(posedge clk_i) begin
    #1;
    rnd     = $random(seed);
    ready_q = rnd[0];
  end

  // Storage for write beats
  always @(posedge clk_i) begin
    if (mem_req_i.valid && ready_q && mem_req_i.we) begin
      mem[mem_req_i.addr[dcache_bus_pkg::ADDR_W-1:2]] <= mem_req_i.wdata;
    end
  end

  // ----------------------------------------
  // Burst order and hold rule
  // ----------------------------------------
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_cnt    <= 0;
      next_addr   <= '0;
      burst_we    <= 1'b0;
      pend_q      <= 1'b0;
      last_req_q  <= '0;
      order_err_o <= 1'b0;
      hold_err_o  <= 1'b0;
    end else begin
      if (pend_q && (mem_req_i != last_req_q)) hold_err_o <= 1'b1;
      pend_q     <= mem_req_i.valid && !ready_q;
      last_req_q <= mem_req_i;
      if (mem_req_i.valid && ready_q) begin
        if (beat_cnt == 0) begin
          if (mem_req_i.addr[LINE_LSB-1:0] != '0) order_err_o <= 1'b1; // Line base
          burst_we <= mem_req_i.we;
        end else if (mem_req_i.addr != next_addr || mem_req_i.we != burst_we) begin
          order_err_o <= 1'b1;
        end
        next_addr <= mem_req_i.addr + 16'd4;
        beat_cnt  <= (beat_cnt == LINE_WORDS - 1) ? 0 : beat_cnt + 1;
      end
    end
  end

endmodule

// File: verif/dcache_tb.sv
// Data cache testbench

`timescale 1ns/1ps

module dcache_tb;

  localparam int SETS       = dcache_cfg_pkg::DEF_SETS;
  localparam int LINE_WORDS = dcache_cfg_pkg::DEF_LINE_WORDS;
  localparam int N_REQ      = 400;
  localparam int MAX_CYCLES = N_REQ * (2 + 2 * LINE_WORDS * 8) + 20; // Plus reset and idle
  localparam int WORDS      = 2 ** (dcache_bus_pkg::ADDR_W - 2);

  logic                     clk_i;
  logic                     rst_ni;
  dcache_bus_pkg::cpu_req_t cpu_req;
  dcache_bus_pkg::cpu_rsp_t cpu_rsp;
  dcache_bus_pkg::mem_req_t mem_req;
  dcache_bus_pkg::mem_rsp_t mem_rsp;
  logic                     order_err, hold_err;

  logic [31:0] ref_mem [WORDS];
  logic [15:0] pool [8];
  logic [11:0] last_line;
  logic        have_last;
  logic        mem_seen; // Memory valid seen during the current request
  int          cycles;
  integer      seed;

  dcache_top #(
    .SETS       (SETS),
    .LINE_WORDS (LINE_WORDS)
  ) dcache_top_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cpu_req_i  (cpu_req),
    .cpu_rsp_o  (cpu_rsp),
    .mem_req_o  (mem_req),
    .mem_rsp_i  (mem_rsp)
  );

  dcache_mem_model #(
    .LINE_WORDS  (LINE_WORDS)
  ) mem_model_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .mem_req_i   (mem_req),
    .mem_rsp_o   (mem_rsp),
    .order_err_o (order_err),
    .hold_err_o  (hold_err)
  );

  always #10 clk_i = ~clk_i;

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "Stopped at first error");
  endtask

  // ----------------------------------------
  // Monitors and timeout
  // ----------------------------------------
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      report_fail($sformatf("Timeout after %0d cycles, a request was never acknowledged", cycles));
    end
  end

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (mem_req.valid) mem_seen = 1'b1;
      // Write back must carry the latest value of the word
      if (mem_req.valid && mem_rsp.ready && mem_req.we) begin
        assert (mem_req.wdata == ref_mem[mem_req.addr[15:2]]) else
          report_fail($sformatf("Fail at %0t: mem_req_o.wdata @%h got %h expected %h", $time,
                                mem_req.addr, mem_req.wdata, ref_mem[mem_req.addr[15:2]]));
      end
      assert (!order_err) else
        report_fail("Memory burst was not line aligned, ascending and complete");
      assert (!hold_err) else
        report_fail("Memory request changed while waiting for ready");
    end
  end

  // One CPU request, entered and left 1 ns after an edge
  task automatic run_request(input logic we, input logic [15:0] addr, input logic [31:0] wdata);
    int   n;
    logic same_line;
    same_line     = have_last && (addr[15:4] == last_line);
    cpu_req.valid = 1'b1;
    cpu_req.we    = we;
    cpu_req.addr  = addr;
    cpu_req.wdata = wdata;
    mem_seen      = 1'b0;
    n             = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!cpu_rsp.ack);
    if (we) begin
      ref_mem[addr[15:2]] = wdata;
    end else begin
      assert (cpu_rsp.rdata == ref_mem[addr[15:2]]) else
        report_fail($sformatf("Fail at %0t: cpu_rsp_o.rdata @%h got %h expected %h", $time,
                              addr, cpu_rsp.rdata, ref_mem[addr[15:2]]));
    end
    if (same_line) begin
      assert (n == 2) else
        report_fail($sformatf("Fail at %0t: ack latency got %0d expected %0d", $time, n, 2));
      assert (!mem_seen) else
        report_fail("A memory beat appeared during a request that hits");
    end
    last_line = addr[15:4];
    have_last = 1'b1;
    #1;
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    logic [31:0] r;
    logic [15:0] addr;
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    cpu_req   = '0;
    cycles    = 0;
    have_last = 1'b0;
    last_line = '0;
    mem_seen  = 1'b0;
    seed      = 32'hd1876156;
    for (int i = 0; i < WORDS; i++) begin
      ref_mem[i] = (32'(i) << 2) ^ 32'h5a5a0000;
    end
    // Sets 0, 1 and 2 are shared by several tags
    pool[0] = 16'h0000;
    pool[1] = 16'h0100;
    pool[2] = 16'h2300;
    pool[3] = 16'h0010;
    pool[4] = 16'h4510;
    pool[5] = 16'h6720;
    pool[6] = 16'h8920;
    pool[7] = 16'hab00;

    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    repeat (3) begin
      @(posedge clk_i);
      assert (!cpu_rsp.ack && !mem_req.valid) else
        report_fail("Ack or memory valid went high before the first request");
    end
    #1;

    for (int k = 0; k < N_REQ; k++) begin
      r    = $random(seed);
      addr = pool[r[2:0]] | {12'b0, r[4:3], 2'b00};
      run_request(r[5], addr, $random(seed));
      if (r[7:6] == 2'b00) begin // Idle gap now and then
        cpu_req.valid = 1'b0;
        @(posedge clk_i);
        #1;
      end
    end
    cpu_req.valid = 1'b0;
    repeat (2) @(posedge clk_i);

    if (!order_err && !hold_err) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
logic/dcache_bus_pkg.sv
logic/dcache_cfg_pkg.sv
logic/dcache_ram.sv
logic/dcache_burst_cnt.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
verif/dcache_mem_model.sv
verif/dcache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= dcache_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf $(OBJ_DIR)
